/* sim.f */
+incdir+include
hw/patch_pkg.sv
hw/thread_fifo.sv
hw/switch_arbiter.sv
hw/dispatch_lane.sv
hw/thread_context_store.sv
hw/patch_dispatcher.sv
dv/patch_dispatcher_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the patch dispatcher testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f sim.f --top-module patch_dispatcher_tb -o patch_sim

./obj_dir/patch_sim | tee sim.log

if grep -q "^test passed$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* dv/patch_trace.txt */
# C repeat load load_done pixel task_done switch_rt switch_ic (one cycle each)
# R core tid pc sp / I core tid (held core data); E side core tid pixel pc sp
C 1 1 0 00007000 0 0 0
C 1 1 0 00007001 0 0 0
C 1 1 0 00007002 0 0 0
C 1 1 0 00007003 0 0 0
C 1 1 0 00007004 0 0 0
C 1 1 0 00007005 0 0 0
C 1 0 1 00000000 0 0 0
C 5 0 0 00000000 0 0 0
C 1 0 0 00000000 4 0 0
C 1 0 0 00000000 8 0 0
C 2 0 0 00000000 0 0 0
R 1 1 00000120 8001ff00
C 1 0 0 00000000 0 2 0
R 0 0 00000340 8000fe80
R 2 4 00000560 8004fd00
C 1 0 0 00000000 0 5 0
C 3 0 0 00000000 0 0 0
I 0 1
I 1 0
I 2 4
C 1 0 0 00000000 0 0 2
C 1 0 0 00000000 0 0 1
C 1 0 0 00000000 0 0 4
C 2 0 0 00000000 0 0 0
C 1 0 0 00000000 3 0 0
C 1 0 0 00000000 c 0 0
C 2 0 0 00000000 0 0 0
C 1 1 0 0000a000 0 0 0
C 1 1 0 0000a001 0 0 0
C 1 0 1 00000000 0 0 0
C 6 0 0 00000000 0 0 0
E 0 0 0 00007000 00000000 80000000
E 0 1 1 00007001 00000000 80010000
E 0 2 2 00007002 00000000 80020000
E 0 3 3 00007003 00000000 80030000
E 0 2 4 00007004 00000000 80040000
E 0 3 5 00007005 00000000 80050000
E 1 0 1 00000000 00000000 00000000
E 1 1 0 00000000 00000000 00000000
E 1 2 4 00000000 00000000 00000000
E 0 0 0 00007000 00000340 8000fe80
E 0 1 1 00007001 00000120 8001ff00
E 0 2 4 00007004 00000560 8004fd00
E 2 0 0 00000000 00000000 00000000
E 0 0 0 0000a000 00000000 80000000
E 0 1 1 0000a001 00000000 80010000

/* dv/patch_dispatcher_tb.sv */
`timescale 1ns/1ps

`include "patch_consts.svh"

module patch_dispatcher_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int TID_W        = `PATCH_TID_W;
    localparam int WORD_W       = `PATCH_WORD_W;

    logic                               clk;
    logic                               rst_n;
    logic                               load;
    logic                               load_done;
    logic [WORD_W-1:0]                  pixel_id;
    logic [`PATCH_NUM_RT-1:0]           task_done_rt;
    logic [`PATCH_NUM_RT-1:0]           switch_rt;
    logic [`PATCH_NUM_RT*TID_W-1:0]     tid_in_rt;
    logic [`PATCH_NUM_RT*WORD_W-1:0]    pc_in_rt;
    logic [`PATCH_NUM_RT*WORD_W-1:0]    sp_in_rt;
    logic [`PATCH_NUM_IC-1:0]           switch_ic;
    logic [`PATCH_NUM_IC*TID_W-1:0]     tid_in_ic;
    logic [`PATCH_NUM_RT-1:0]           dispatch_rt;
    logic [TID_W-1:0]                   tid_out_rt;
    logic [WORD_W-1:0]                  pixel_out_rt;
    logic [WORD_W-1:0]                  pc_out_rt;
    logic [WORD_W-1:0]                  sp_out_rt;
    logic [`PATCH_NUM_IC-1:0]           dispatch_ic;
    logic [TID_W-1:0]                   tid_out_ic;
    logic [`PATCH_NUM_RT-1:0]           accept_rt;
    logic [`PATCH_NUM_IC-1:0]           accept_ic;
    logic                               patch_done;

    // trace contents and run bookkeeping
    string                    stim_q[$];
    logic [31:0]              exp_side[$];
    logic [31:0]              exp_core[$];
    logic [31:0]              exp_tid[$];
    logic [31:0]              exp_pixel[$];
    logic [31:0]              exp_pc[$];
    logic [31:0]              exp_sp[$];
    int                       errors;
    int                       checks;
    int                       trace_lines;
    logic                     trace_loaded;
    logic                     trace_ok;
    logic [`PATCH_NUM_RT-1:0] held_rt;
    logic [`PATCH_NUM_IC-1:0] held_ic;
    logic [`PATCH_NUM_RT-1:0] acc_rt_seen;
    logic [`PATCH_NUM_IC-1:0] acc_ic_seen;
    int                       cycle_cnt;
    int                       ic_due[$];
    logic [`PATCH_NUM_IC-1:0] ic_busy;

    patch_dispatcher dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .load_done    (load_done),
        .pixel_id     (pixel_id),
        .task_done_rt (task_done_rt),
        .switch_rt    (switch_rt),
        .tid_in_rt    (tid_in_rt),
        .pc_in_rt     (pc_in_rt),
        .sp_in_rt     (sp_in_rt),
        .switch_ic    (switch_ic),
        .tid_in_ic    (tid_in_ic),
        .dispatch_rt  (dispatch_rt),
        .tid_out_rt   (tid_out_rt),
        .pixel_out_rt (pixel_out_rt),
        .pc_out_rt    (pc_out_rt),
        .sp_out_rt    (sp_out_rt),
        .dispatch_ic  (dispatch_ic),
        .tid_out_ic   (tid_out_ic),
        .accept_rt    (accept_rt),
        .accept_ic    (accept_ic),
        .patch_done   (patch_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // the lowest raised switch line is the one accepted
    function automatic logic [31:0] lowest_core(input logic [31:0] lines);
        logic [31:0] pick;
        pick = '0;
        for (int i = 31; i >= 0; i--) begin
            if (lines[i]) begin
                pick = 32'h1 << i;
            end
        end
        return pick;
    endfunction

    task automatic load_trace(output logic ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        fd = $fopen("dv/patch_trace.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0) begin
                    if (line[0] == "E") begin
                        n = $sscanf(line, "E %h %h %h %h %h %h", a, b, c, d, e, f);
                        exp_side.push_back(a);
                        exp_core.push_back(b);
                        exp_tid.push_back(c);
                        exp_pixel.push_back(d);
                        exp_pc.push_back(e);
                        exp_sp.push_back(f);
                        trace_lines++;
                    end else if (line[0] == "C" || line[0] == "R" || line[0] == "I") begin
                        stim_q.push_back(line);
                        trace_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one trace line; C lines take their cycles, R and I lines take no time
    task automatic apply_line(input string line);
        int          n;
        int          rep;
        int          core;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        if (line[0] == "R") begin
            n = $sscanf(line, "R %d %h %h %h", core, a, b, c);
            tid_in_rt[core*TID_W +: TID_W] = a[TID_W-1:0];
            pc_in_rt[core*WORD_W +: WORD_W] = b;
            sp_in_rt[core*WORD_W +: WORD_W] = c;
        end else if (line[0] == "I") begin
            n = $sscanf(line, "I %d %h", core, a);
            tid_in_ic[core*TID_W +: TID_W] = a[TID_W-1:0];
        end else begin
            n = $sscanf(line, "C %d %h %h %h %h %h %h", rep, a, b, c, d, e, f);
            repeat (rep) begin
                // a core keeps its switch line up until it has seen its accept
                held_rt      = (held_rt & ~acc_rt_seen) | e[`PATCH_NUM_RT-1:0];
                held_ic      = (held_ic & ~acc_ic_seen) | f[`PATCH_NUM_IC-1:0];
                load         = a[0];
                load_done    = b[0];
                pixel_id     = c;
                task_done_rt = d[`PATCH_NUM_RT-1:0];
                switch_rt    = held_rt;
                switch_ic    = held_ic;
                #1;
                acc_rt_seen = accept_rt;
                acc_ic_seen = accept_ic;
                check_value("accept_rt", 32'(accept_rt), lowest_core(32'(switch_rt)));
                check_value("accept_ic", 32'(accept_ic), lowest_core(32'(switch_ic)));
                if (accept_rt != '0) begin
                    // a lone thread with a free ic core reaches it 2 cycles after accept
                    if (ic_due.size() == 0 && ic_busy != '1) begin
                        ic_due.push_back(cycle_cnt + 2);
                    end else begin
                        ic_due.push_back(-1);
                    end
                end
                ic_busy = ic_busy & ~accept_ic;
                @(negedge clk);
            end
        end
    endtask

    task automatic match_event(input int side, input int core, input logic [31:0] tid,
                               input logic [31:0] pixel, input logic [31:0] pc,
                               input logic [31:0] sp);
        logic [31:0] e_side;
        logic [31:0] e_core;
        logic [31:0] e_tid;
        logic [31:0] e_pixel;
        logic [31:0] e_pc;
        logic [31:0] e_sp;
        if (exp_side.size() == 0) begin
            errors++;
            $display("unexpected event at %0t ns: side %0d core %0d thread %0d",
                     $time, side, core, tid);
        end else begin
            e_side  = exp_side.pop_front();
            e_core  = exp_core.pop_front();
            e_tid   = exp_tid.pop_front();
            e_pixel = exp_pixel.pop_front();
            e_pc    = exp_pc.pop_front();
            e_sp    = exp_sp.pop_front();
            check_value("event side", 32'(side), e_side);
            // patch_done carries no core or thread
            if (side != 2) begin
                check_value("dispatch core", 32'(core), e_core);
                check_value("thread id", tid, e_tid);
            end
            // only an rt dispatch carries a context
            if (side == 0) begin
                check_value("pixel id", pixel, e_pixel);
                check_value("pc", pc, e_pc);
                check_value("sp", sp, e_sp);
            end
        end
    endtask

    // monitored outputs change only on the rising edge
    always @(negedge clk) begin
        int due;
        if (rst_n) begin
            for (int i = 0; i < `PATCH_NUM_RT; i++) begin
                if (dispatch_rt[i]) begin
                    match_event(0, i, 32'(tid_out_rt), pixel_out_rt, pc_out_rt, sp_out_rt);
                end
            end
            for (int i = 0; i < `PATCH_NUM_IC; i++) begin
                if (dispatch_ic[i]) begin
                    match_event(1, i, 32'(tid_out_ic), 32'h0, 32'h0, 32'h0);
                    ic_busy[i] = 1'b1;
                    if (ic_due.size() != 0) begin
                        due = ic_due.pop_front();
                        if (due >= 0) begin
                            check_value("ic dispatch cycle", 32'(cycle_cnt), 32'(due));
                        end
                    end
                end
            end
            if (patch_done) begin
                match_event(2, 0, 32'h0, 32'h0, 32'h0, 32'h0);
            end
        end
    end

    initial begin
        wait (trace_loaded);
        #(trace_lines * 4 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", trace_lines * 4);
        $display("test failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        load         = 1'b0;
        load_done    = 1'b0;
        pixel_id     = '0;
        task_done_rt = '0;
        switch_rt    = '0;
        tid_in_rt    = '0;
        pc_in_rt     = '0;
        sp_in_rt     = '0;
        switch_ic    = '0;
        tid_in_ic    = '0;
        held_rt      = '0;
        held_ic      = '0;
        acc_rt_seen  = '0;
        acc_ic_seen  = '0;
        ic_busy      = '0;
        cycle_cnt    = 0;
        errors       = 0;
        checks       = 0;
        trace_lines  = 0;
        trace_loaded = 1'b0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("could not open the trace file dv/patch_trace.txt");
            $display("test failed");
        end else begin
            trace_loaded = 1'b1;
            repeat (RESET_CYCLES) @(negedge clk);
            check_value("dispatch_rt in reset", 32'(dispatch_rt), 32'h0);
            check_value("dispatch_ic in reset", 32'(dispatch_ic), 32'h0);
            check_value("accept_rt in reset", 32'(accept_rt), 32'h0);
            check_value("accept_ic in reset", 32'(accept_ic), 32'h0);
            check_value("patch_done in reset", 32'(patch_done), 32'h0);
            rst_n = 1'b1;
            foreach (stim_q[k]) begin
                apply_line(stim_q[k]);
            end
            // wait for the last expected events
            while (exp_side.size() != 0) begin
                @(negedge clk);
            end
            repeat (4) @(negedge clk);
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
        end
        $finish;
    end

endmodule

/* hw/patch_dispatcher.sv */
`timescale 1ns/1ps

`include "patch_consts.svh"

module patch_dispatcher (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     load,
    input  logic                                     load_done,
    input  logic [`PATCH_WORD_W-1:0]                 pixel_id,
    input  logic [`PATCH_NUM_RT-1:0]                 task_done_rt,
    input  logic [`PATCH_NUM_RT-1:0]                 switch_rt,
    input  logic [`PATCH_NUM_RT*`PATCH_TID_W-1:0]    tid_in_rt,
    input  logic [`PATCH_NUM_RT*`PATCH_WORD_W-1:0]   pc_in_rt,
    input  logic [`PATCH_NUM_RT*`PATCH_WORD_W-1:0]   sp_in_rt,
    input  logic [`PATCH_NUM_IC-1:0]                 switch_ic,
    input  logic [`PATCH_NUM_IC*`PATCH_TID_W-1:0]    tid_in_ic,
    output logic [`PATCH_NUM_RT-1:0]                 dispatch_rt,
    output patch_pkg::tid_t                          tid_out_rt,
    output logic [`PATCH_WORD_W-1:0]                 pixel_out_rt,
    output logic [`PATCH_WORD_W-1:0]                 pc_out_rt,
    output logic [`PATCH_WORD_W-1:0]                 sp_out_rt,
    output logic [`PATCH_NUM_IC-1:0]                 dispatch_ic,
    output patch_pkg::tid_t                          tid_out_ic,
    output logic [`PATCH_NUM_RT-1:0]                 accept_rt,
    output logic [`PATCH_NUM_IC-1:0]                 accept_ic,
    output logic                                     patch_done
);
    import patch_pkg::*;

    logic [`PATCH_NUM_IC-1:0] busy_ic;
    logic                     save;
    tid_t                     save_tid;
    logic [`PATCH_WORD_W-1:0] save_pc;
    logic [`PATCH_WORD_W-1:0] save_sp;
    logic                     load_push;
    tid_t                     load_tid;
    logic                     loading;
    logic [`PATCH_NUM_RT-1:0] rt_free;

    // rt to ic: ic core busy from dispatch until its own switch is accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_ic <= '0;
        end else begin
            busy_ic <= (busy_ic | dispatch_ic) & ~accept_ic;
        end
    end

    dispatch_lane #(
        .NUM_SRC (`PATCH_NUM_RT),
        .NUM_DST (`PATCH_NUM_IC)
    ) rt_to_ic (
        .clk        (clk),
        .rst_n      (rst_n),
        .switch     (switch_rt),
        .tid_in     (tid_in_rt),
        .extra_push (1'b0),
        .extra_tid  ('0),
        .hold       (1'b0),
        .free_dst   (~busy_ic),
        .accept     (accept_rt),
        .dispatch   (dispatch_ic),
        .tid_out    (tid_out_ic),
        .issue      ()
    );

    // context of the accepted rt core, saved on the enqueue edge
    always_comb begin
        save_tid = '0;
        save_pc  = '0;
        save_sp  = '0;
        for (int i = 0; i < `PATCH_NUM_RT; i++) begin
            if (accept_rt[i]) begin
                save_tid = save_tid | tid_in_rt[i*`PATCH_TID_W +: `PATCH_TID_W];
                save_pc  = save_pc | pc_in_rt[i*`PATCH_WORD_W +: `PATCH_WORD_W];
                save_sp  = save_sp | sp_in_rt[i*`PATCH_WORD_W +: `PATCH_WORD_W];
            end
        end
    end

    assign save = |accept_rt;

    // ic to rt, also fed by the load sequence
    dispatch_lane #(
        .NUM_SRC (`PATCH_NUM_IC),
        .NUM_DST (`PATCH_NUM_RT)
    ) ic_to_rt (
        .clk        (clk),
        .rst_n      (rst_n),
        .switch     (switch_ic),
        .tid_in     (tid_in_ic),
        .extra_push (load_push),
        .extra_tid  (load_tid),
        .hold       (loading),
        .free_dst   (rt_free),
        .accept     (accept_ic),
        .dispatch   (dispatch_rt),
        .tid_out    (tid_out_rt),
        .issue      ()
    );

    thread_context_store context_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .load_done    (load_done),
        .pixel_id     (pixel_id),
        .save         (save),
        .save_tid     (save_tid),
        .save_pc      (save_pc),
        .save_sp      (save_sp),
        .read_tid     (tid_out_rt),
        .task_done_rt (task_done_rt),
        .dispatch_rt  (dispatch_rt),
        .accept_rt    (accept_rt),
        .load_push    (load_push),
        .load_tid     (load_tid),
        .loading      (loading),
        .rt_free      (rt_free),
        .pixel_out    (pixel_out_rt),
        .pc_out       (pc_out_rt),
        .sp_out       (sp_out_rt),
        .patch_done   (patch_done)
    );

endmodule

/* hw/thread_context_store.sv */
`timescale 1ns/1ps

`include "patch_consts.svh"

module thread_context_store (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,
    input  logic                      load_done,
    input  logic [`PATCH_WORD_W-1:0]  pixel_id,
    input  logic                      save,
    input  patch_pkg::tid_t           save_tid,
    input  logic [`PATCH_WORD_W-1:0]  save_pc,
    input  logic [`PATCH_WORD_W-1:0]  save_sp,
    input  patch_pkg::tid_t           read_tid,
    input  logic [`PATCH_NUM_RT-1:0]  task_done_rt,
    input  logic [`PATCH_NUM_RT-1:0]  dispatch_rt,
    input  logic [`PATCH_NUM_RT-1:0]  accept_rt,
    output logic                      load_push,
    output patch_pkg::tid_t           load_tid,
    output logic                      loading,
    output logic [`PATCH_NUM_RT-1:0]  rt_free,
    output logic [`PATCH_WORD_W-1:0]  pixel_out,
    output logic [`PATCH_WORD_W-1:0]  pc_out,
    output logic [`PATCH_WORD_W-1:0]  sp_out,
    output logic                      patch_done
);
    import patch_pkg::*;

    localparam int CNT_W = `PATCH_TID_W + 1;

    load_state_e              state;
    load_state_e              state_nxt;
    logic                     load_start;
    logic [CNT_W-1:0]         load_cnt;
    logic [CNT_W-1:0]         done_cnt;
    logic [CNT_W-1:0]         done_inc;
    logic [`PATCH_NUM_RT-1:0] rt_busy;
    logic [`PATCH_WORD_W-1:0] pixel_mem [`PATCH_NUM_THREAD];
    logic [`PATCH_WORD_W-1:0] pc_mem    [`PATCH_NUM_THREAD];
    logic [`PATCH_WORD_W-1:0] sp_mem    [`PATCH_NUM_THREAD];

    // stack base with the thread id in the upper half
    function automatic logic [`PATCH_WORD_W-1:0] init_sp(input int t);
        logic [`PATCH_WORD_W-1:0] id;
        id = `PATCH_WORD_W'(tid_t'(t));
        return `PATCH_STACK_BASE | (id << `PATCH_STACK_SHIFT);
    endfunction

    always_comb begin
        state_nxt  = state;
        load_start = 1'b0;
        load_push  = 1'b0;
        case (state)
            LOAD_IDLE: begin
                if (load) begin
                    state_nxt  = LOAD_LOADING;
                    load_start = 1'b1;
                    load_push  = 1'b1;
                end
            end
            LOAD_LOADING: begin
                if (load_done) begin
                    state_nxt = LOAD_IDLE;
                end else if (load) begin
                    load_push = 1'b1;
                end
            end
            default: begin
                state_nxt = LOAD_IDLE;
            end
        endcase
    end

    assign loading  = (state == LOAD_LOADING) | load;
    assign load_tid = load_cnt[`PATCH_TID_W-1:0];

    always_comb begin
        done_inc = '0;
        for (int i = 0; i < `PATCH_NUM_RT; i++) begin
            done_inc = done_inc + CNT_W'(task_done_rt[i]);
        end
    end

    assign patch_done = (state == LOAD_IDLE) && (done_cnt != '0) && (done_cnt == load_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LOAD_IDLE;
            load_cnt <= '0;
            done_cnt <= '0;
            rt_busy  <= '0;
        end else begin
            state   <= state_nxt;
            rt_busy <= (rt_busy | dispatch_rt) & ~(accept_rt | task_done_rt);
            if (patch_done) begin
                load_cnt <= '0;
                done_cnt <= '0;
            end else begin
                if (load_push) begin
                    load_cnt <= load_cnt + 1'b1;
                end
                done_cnt <= done_cnt + done_inc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_push) begin
            pixel_mem[load_tid] <= pixel_id;
        end
        // a new patch restarts every thread from pc 0
        if (load_start) begin
            for (int t = 0; t < `PATCH_NUM_THREAD; t++) begin
                pc_mem[t] <= '0;
                sp_mem[t] <= init_sp(t);
            end
        end else if (save) begin
            pc_mem[save_tid] <= save_pc;
            sp_mem[save_tid] <= save_sp;
        end
    end

    assign rt_free = ~rt_busy;

    // read_tid is already registered in the lane, in step with the pulse
    assign pixel_out = pixel_mem[read_tid];
    assign pc_out    = pc_mem[read_tid];
    assign sp_out    = sp_mem[read_tid];

endmodule

/* hw/dispatch_lane.sv */
`timescale 1ns/1ps

`include "patch_consts.svh"

module dispatch_lane #(
    parameter int NUM_SRC = `PATCH_NUM_RT,
    parameter int NUM_DST = `PATCH_NUM_IC
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [NUM_SRC-1:0]             switch,
    input  logic [NUM_SRC*`PATCH_TID_W-1:0] tid_in,
    input  logic                           extra_push,
    input  patch_pkg::tid_t                extra_tid,
    input  logic                           hold,
    input  logic [NUM_DST-1:0]             free_dst,
    output logic [NUM_SRC-1:0]             accept,
    output logic [NUM_DST-1:0]             dispatch,
    output patch_pkg::tid_t                tid_out,
    output logic                           issue
);
    import patch_pkg::*;

    logic               any_accept;
    tid_t               sel_tid;
    logic               push;
    tid_t               push_tid;
    logic               empty;
    tid_t               head_tid;
    logic [NUM_DST-1:0] avail;
    logic [NUM_DST-1:0] target;

    switch_arbiter #(
        .NUM_CORES (NUM_SRC)
    ) u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .request    (switch),
        .accept     (accept),
        .any_accept (any_accept)
    );

    // accept is one-hot, so an OR mux is enough
    always_comb begin
        sel_tid = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (accept[i]) begin
                sel_tid = sel_tid | tid_in[i*`PATCH_TID_W +: `PATCH_TID_W];
            end
        end
    end

    assign push     = any_accept | extra_push;
    assign push_tid = extra_push ? extra_tid : sel_tid;

    thread_fifo #(
        .DEPTH (`PATCH_NUM_THREAD)
    ) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .pop      (issue),
        .push_tid (push_tid),
        .empty    (empty),
        .head_tid (head_tid)
    );

    // a core under this cycle's pulse is not yet marked busy
    assign avail  = free_dst & ~dispatch;
    assign target = avail & (~avail + NUM_DST'(1));
    assign issue  = ~empty & (|avail) & ~hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dispatch <= '0;
        end else begin
            dispatch <= issue ? target : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tid_out <= head_tid;
        end
    end

endmodule

/* hw/switch_arbiter.sv */
`timescale 1ns/1ps

`include "patch_consts.svh"

module switch_arbiter #(
    parameter int NUM_CORES = `PATCH_NUM_RT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_CORES-1:0] request,
    output logic [NUM_CORES-1:0] accept,
    output logic                 any_accept
);
    import patch_pkg::*;

    switch_state_e        state     [NUM_CORES];
    switch_state_e        state_nxt [NUM_CORES];
    logic [NUM_CORES-1:0] pending;

    // lowest pending core wins, one per cycle
    assign accept     = pending & (~pending + NUM_CORES'(1));
    assign any_accept = |pending;

    genvar i;
    generate
        for (i = 0; i < NUM_CORES; i++) begin : g_core
            assign pending[i] = request[i] | (state[i] == SW_WAIT);

            always_comb begin
                state_nxt[i] = state[i];
                case (state[i])
                    SW_IDLE: begin
                        if (request[i] && !accept[i]) begin
                            state_nxt[i] = SW_WAIT;
                        end
                    end
                    SW_WAIT: begin
                        if (accept[i]) begin
                            state_nxt[i] = SW_IDLE;
                        end
                    end
                    default: begin
                        state_nxt[i] = SW_IDLE;
                    end
                endcase
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    state[i] <= SW_IDLE;
                end else begin
                    state[i] <= state_nxt[i];
                end
            end
        end
    endgenerate

endmodule

/* hw/thread_fifo.sv */
`timescale 1ns/1ps

`include "patch_consts.svh"

module thread_fifo #(
    parameter int DEPTH = `PATCH_NUM_THREAD
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  logic           pop,
    input  patch_pkg::tid_t push_tid,
    output logic           empty,
    output patch_pkg::tid_t head_tid
);
    import patch_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    tid_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign do_pop   = pop & ~empty;
    assign empty    = (count == '0);
    assign head_tid = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_tid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/patch_pkg.sv */
`include "patch_consts.svh"

package patch_pkg;

    // thread id carried between the lanes and the cores
    typedef logic [`PATCH_TID_W-1:0] tid_t;

    // command processor load sequence
    typedef enum logic {
        LOAD_IDLE,
        LOAD_LOADING
    } load_state_e;

    // per-core switch request, WAIT while not yet accepted
    typedef enum logic {
        SW_IDLE,
        SW_WAIT
    } switch_state_e;

endpackage

/* include/patch_consts.svh */
`ifndef PATCH_CONSTS_SVH
`define PATCH_CONSTS_SVH

// core counts on each side of the patch engine
`define PATCH_NUM_RT 4
`define PATCH_NUM_IC 4

// threads per patch, one per loaded pixel
`define PATCH_NUM_THREAD 32
`define PATCH_TID_W 5

// pixel id, pc and sp width
`define PATCH_WORD_W 32

// top bit of every initial sp, thread id goes at bit 16
`define PATCH_STACK_BASE 32'h8000_0000
`define PATCH_STACK_SHIFT 16

`endif
